// ==== vlog.f ====
common/abc80_kbd_pkg.sv
keyboard/kbd_modifiers.sv
keyboard/kbd_scan_translate.sv
keyboard/kbd_key_queue.sv
keyboard/abc80_keyboard.sv
tb/kbd_checker.sv
tb/tb_abc80_keyboard.sv

// ==== Makefile ====
SRCS := $(shell cat vlog.f)

obj_dir/Vtb_abc80_keyboard: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_abc80_keyboard -f vlog.f

run: obj_dir/Vtb_abc80_keyboard
	@out="$$(./obj_dir/Vtb_abc80_keyboard)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== tb/tb_abc80_keyboard.sv ====
/* ABC80 keyboard front end testbench
   Random PS/2 events from a key table, reference model, checker and watchdog */
`timescale 1ns/1ps

module tb_abc80_keyboard import abc80_kbd_pkg::*; ();

	localparam int NUM_EVENTS   = 400;
	localparam int EVENT_CYCLES = 600;   // Strobe to strobe
	localparam int DRAIN_CYCLES = 2 * 256;   // Two bytes at one per pace period
	localparam int K_LETTER = 0;
	localparam int K_DIGIT  = 1;
	localparam int K_PLAIN  = 2;         // Mapped only without modifiers
	localparam int K_SHIFT  = 3;
	localparam int K_CTRL   = 4;
	localparam int K_CAPS   = 5;
	localparam int K_NONE   = 6;

	logic       CLK12 = 1'b0;
	logic       RESET;
	logic       key_strobe;
	logic       key_pressed;
	logic       key_extended;
	logic [7:0] key_code;
	key_byte_t  key_byte;
	logic       upcase;
	logic       exp_push;
	key_byte_t  exp_byte;
	logic       exp_upcase;
	logic       done;
	int         errors;
	int         pending;
	integer     seed;

	int         tbl_kind [$];
	scan_code_t tbl_scan [$];
	key_char_t  tbl_base [$];
	key_char_t  tbl_alt [$];    // Shifted digit symbol

	logic       m_shift;
	logic       m_ctrl;
	logic       m_upcase;
	key_byte_t  m_last;         // Last queued entry

	always #5 CLK12 = ~CLK12;

	abc80_keyboard abc80_keyboard_inst (
		.CLK12        (CLK12),
		.RESET        (RESET),
		.key_strobe   (key_strobe),
		.key_pressed  (key_pressed),
		.key_extended (key_extended),
		.key_code     (key_code),
		.key_byte     (key_byte),
		.upcase       (upcase)
	);

	kbd_checker kbd_checker_inst (
		.CLK12      (CLK12),
		.RESET      (RESET),
		.key_strobe (key_strobe),
		.key_byte   (key_byte),
		.upcase     (upcase),
		.exp_push   (exp_push),
		.exp_byte   (exp_byte),
		.exp_upcase (exp_upcase),
		.done       (done),
		.errors     (errors),
		.pending    (pending)
	);

	task automatic add_key(int kind, scan_code_t scan, key_char_t base, key_char_t alt);
		tbl_kind.push_back(kind);
		tbl_scan.push_back(scan);
		tbl_base.push_back(base);
		tbl_alt.push_back(alt);
	endtask

	task automatic build_table();
		add_key(K_LETTER, 9'h01C, 7'h41, 7'h00);   // A
		add_key(K_LETTER, 9'h021, 7'h43, 7'h00);   // C
		add_key(K_LETTER, 9'h024, 7'h45, 7'h00);   // E
		add_key(K_LETTER, 9'h042, 7'h4B, 7'h00);   // K
		add_key(K_LETTER, 9'h022, 7'h58, 7'h00);   // X
		add_key(K_LETTER, 9'h01A, 7'h5A, 7'h00);   // Z
		add_key(K_DIGIT,  9'h016, 7'h31, 7'h21);   // 1 !
		add_key(K_DIGIT,  9'h026, 7'h33, 7'h23);   // 3 #
		add_key(K_DIGIT,  9'h03D, 7'h37, 7'h2F);   // 7 /
		add_key(K_DIGIT,  9'h045, 7'h30, 7'h3D);   // 0 =
		add_key(K_PLAIN,  9'h029, 7'h20, 7'h00);   // Space
		add_key(K_PLAIN,  9'h05A, 7'h0D, 7'h00);   // Enter
		add_key(K_SHIFT,  9'h012, 7'h00, 7'h00);
		add_key(K_SHIFT,  9'h059, 7'h00, 7'h00);
		add_key(K_CTRL,   9'h014, 7'h00, 7'h00);
		add_key(K_CTRL,   9'h114, 7'h00, 7'h00);   // Right Ctrl
		add_key(K_CAPS,   9'h058, 7'h00, 7'h00);
		add_key(K_NONE,   9'h076, 7'h00, 7'h00);   // Esc has no ABC80 code
	endtask

	// Character for a table key under the current modifiers, 0 when unmapped
	function automatic logic map_key(input int idx, output key_char_t chr);
		key_char_t base;
		base = tbl_base[idx];
		chr  = base;
		case (tbl_kind[idx])
			K_LETTER: begin
				if (!m_ctrl) begin
					chr = (m_shift == m_upcase) ? (base | 7'h20) : base;
					return 1'b1;
				end
				chr = (base == 7'h43) ? 7'h03 : 7'h18;   // Ctrl+C or Ctrl+X
				return !m_shift && (base == 7'h43 || base == 7'h58);
			end
			K_DIGIT: begin
				chr = m_shift ? tbl_alt[idx] : base;
				return !m_ctrl;
			end
			K_PLAIN: return !m_ctrl && !m_shift;
			default: return 1'b0;
		endcase
	endfunction

	task automatic apply_reset();
		RESET = 1'b1;
		repeat (2) @(posedge CLK12);
		@(negedge CLK12);
		RESET      = 1'b0;
		m_shift    = 1'b0;
		m_ctrl     = 1'b0;
		m_upcase   = 1'b0;
		m_last     = '0;
		exp_upcase = 1'b0;
	endtask

	task automatic push_expected(key_byte_t b);
		exp_push = 1'b1;
		exp_byte = b;
		@(negedge CLK12);
		exp_push = 1'b0;
	endtask

	// One strobed event, then idle until the next event slot
	task automatic send_event(int idx, logic pressed);
		key_char_t chr;
		logic      hit;
		key_byte_t nb;
		key_byte_t rel;
		int        used;
		hit  = map_key(idx, chr);
		used = 1;
		key_strobe                = 1'b1;
		key_pressed               = pressed;
		{key_extended, key_code}  = tbl_scan[idx];
		case (tbl_kind[idx])
			K_SHIFT: m_shift = pressed;
			K_CTRL:  m_ctrl = pressed;
			K_CAPS:  m_upcase = m_upcase ^ pressed;   // Presses toggle
			default: ;
		endcase
		exp_upcase = m_upcase;
		@(negedge CLK12);
		key_strobe = 1'b0;
		nb = '{down: pressed, chr: chr};
		if (hit && nb != m_last) begin
			if (pressed && m_last.down) begin
				rel      = m_last;
				rel.down = 1'b0;
				push_expected(rel);   // Held key released first
				used++;
			end
			push_expected(nb);
			used++;
			m_last = nb;
		end
		repeat (EVENT_CYCLES - used) @(negedge CLK12);
	endtask

	initial begin
		int   idx;
		logic pressed;
		seed         = 92244;
		RESET        = 1'b1;
		key_strobe   = 1'b0;
		key_pressed  = 1'b0;
		key_extended = 1'b0;
		key_code     = 8'h00;
		exp_push     = 1'b0;
		exp_byte     = '0;
		exp_upcase   = 1'b0;
		done         = 1'b0;
		build_table();
		apply_reset();
		for (int n = 0; n < NUM_EVENTS; n++) begin
			if (n == NUM_EVENTS / 2) begin
				wait (pending == 0);
				@(negedge CLK12);
				apply_reset();   // Mid-run reset clears upcase and the queue
			end
			idx     = $unsigned($random(seed)) % tbl_kind.size();
			pressed = ($random(seed) % 2) != 0;
			send_event(idx, pressed);
		end
		// Last bytes get a bounded drain, anything left is reported missing
		for (int i = 0; i < DRAIN_CYCLES && pending != 0; i++)
			@(negedge CLK12);
		repeat (300) @(negedge CLK12);
		done = 1'b1;
		@(negedge CLK12);
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// ====================
	// Watchdog
	// ====================

	initial begin
		repeat (NUM_EVENTS * EVENT_CYCLES + 2000) @(posedge CLK12);
		$display("Timeout: the run did not finish within %0d cycles",
			NUM_EVENTS * EVENT_CYCLES + 2000);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== tb/kbd_checker.sv ====
/* Keyboard front end checker
   Compares key_byte changes and upcase with the expected results of the testbench model */
`timescale 1ns/1ps

module kbd_checker import abc80_kbd_pkg::*; (
	input  logic      CLK12,
	input  logic      RESET,
	input  logic      key_strobe,
	input  key_byte_t key_byte,
	input  logic      upcase,
	input  logic      exp_push,     // Append exp_byte to the expected list
	input  key_byte_t exp_byte,
	input  logic      exp_upcase,
	input  logic      done,         // End of stimulus
	output int        errors,
	output int        pending       // Expected bytes not seen yet
);

	key_byte_t expected [$];
	key_byte_t prev_byte;
	key_byte_t want;
	logic      strobe_q;
	logic      reset_q;
	logic      done_q;

	initial begin
		errors   = 0;
		pending  = 0;
		strobe_q = 1'b0;
		reset_q  = 1'b0;
		done_q   = 1'b0;
	end

	always @(posedge CLK12) begin
		if (exp_push)
			expected.push_back(exp_byte);
		if (RESET) begin
			prev_byte = '0;
		end else begin
			// ====================
			// Reset state
			// ====================
			if (reset_q && key_byte !== '0) begin
				$display("Mismatch at %0t: key_byte expected 00, got %h", $time, key_byte);
				errors++;
			end
			if (reset_q && upcase !== 1'b0) begin
				$display("Mismatch at %0t: upcase expected 0, got %b", $time, upcase);
				errors++;
			end

			// Every visible change is the next queued byte
			if (key_byte !== prev_byte) begin
				if (expected.size() == 0) begin
					$display("Unexpected change of key_byte at %0t to %h", $time, key_byte);
					errors++;
				end else begin
					want = expected.pop_front();
					if (key_byte !== want) begin
						$display("Mismatch at %0t: key_byte expected %h, got %h",
							$time, want, key_byte);
						errors++;
					end
				end
				prev_byte = key_byte;
			end

			if (strobe_q && upcase !== exp_upcase) begin   // One cycle after the event
				$display("Mismatch at %0t: upcase expected %b, got %b",
					$time, exp_upcase, upcase);
				errors++;
			end
		end

		if (done && !done_q && expected.size() != 0) begin
			$display("%0d expected key bytes never appeared on key_byte", expected.size());
			errors += expected.size();
		end

		strobe_q = key_strobe;
		reset_q  = RESET;
		done_q   = done;
		pending  = expected.size();
	end

endmodule

// ==== keyboard/abc80_keyboard.sv ====
/* ABC80 keyboard front end top level
   PS/2 events in, paced ABC80 key bytes and the upcase indicator out */
`timescale 1ns/1ps

module abc80_keyboard import abc80_kbd_pkg::*; #(
	parameter int QUEUE_DEPTH = 8,
	parameter int PACE_BITS   = 8
) (
	input  logic       CLK12,
	input  logic       RESET,
	input  logic       key_strobe,
	input  logic       key_pressed,
	input  logic       key_extended,
	input  logic [7:0] key_code,
	output key_byte_t  key_byte,
	output logic       upcase
);

	logic      shift;
	logic      ctrl;
	logic      key_down;
	key_char_t key_char;

	kbd_modifiers kbd_modifiers_inst (
		.CLK12        (CLK12),
		.RESET        (RESET),
		.key_strobe   (key_strobe),
		.key_pressed  (key_pressed),
		.key_extended (key_extended),
		.key_code     (key_code),
		.shift        (shift),
		.ctrl         (ctrl),
		.upcase       (upcase)
	);

	kbd_scan_translate kbd_scan_translate_inst (
		.CLK12        (CLK12),
		.RESET        (RESET),
		.key_strobe   (key_strobe),
		.key_pressed  (key_pressed),
		.key_extended (key_extended),
		.key_code     (key_code),
		.shift        (shift),
		.ctrl         (ctrl),
		.upcase       (upcase),
		.key_down     (key_down),
		.key_char     (key_char)
	);

	kbd_key_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH),
		.PACE_BITS   (PACE_BITS)
	) kbd_key_queue_inst (
		.CLK12      (CLK12),
		.RESET      (RESET),
		.key_strobe (key_strobe),   // Queue acts on the falling edge
		.key_down   (key_down),
		.key_char   (key_char),
		.key_byte   (key_byte)
	);

endmodule

// ==== keyboard/kbd_key_queue.sv ====
/* Key event ring queue
   Stores translated key events and hands one to the port-A reader per pace period */
`timescale 1ns/1ps

module kbd_key_queue import abc80_kbd_pkg::*; #(
	parameter int QUEUE_DEPTH = 8,
	parameter int PACE_BITS   = 8
) (
	input  logic      CLK12,
	input  logic      RESET,
	input  logic      key_strobe,
	input  logic      key_down,
	input  key_char_t key_char,
	output key_byte_t key_byte
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam logic [PTR_W-1:0] ONE = PTR_W'(1);
	localparam logic [PTR_W-1:0] TWO = PTR_W'(2);

	key_byte_t            entries [QUEUE_DEPTH];
	logic [PTR_W-1:0]     wr_ptr;           // Last written entry
	logic [PTR_W-1:0]     rd_ptr;           // Entry shown to the reader
	logic [PTR_W-1:0]     slot1;
	logic [PTR_W-1:0]     slot2;
	logic [PACE_BITS-1:0] pace_cnt;
	logic                 strobe_q;
	logic                 strobe_fall;
	key_byte_t            new_evt;
	key_byte_t            last_evt;
	logic                 same_evt;
	logic                 wr_pair;          // Insert release of the held key first
	logic                 wr_single;

	assign slot1       = wr_ptr + ONE;
	assign slot2       = wr_ptr + TWO;
	assign strobe_fall = strobe_q & ~key_strobe;   // Translator output is settled here
	assign new_evt     = '{down: key_down, chr: key_char};
	assign last_evt    = entries[wr_ptr];
	assign same_evt    = (new_evt == last_evt);
	assign wr_pair     = strobe_fall && !same_evt && new_evt.down && last_evt.down;
	assign wr_single   = strobe_fall && !same_evt && !wr_pair;

	assign key_byte = entries[rd_ptr];

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			strobe_q <= 1'b0;
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			pace_cnt <= '0;
			for (int i = 0; i < QUEUE_DEPTH; i++)
				entries[i] <= '0;
		end else begin
			strobe_q <= key_strobe;
			pace_cnt <= pace_cnt + PACE_BITS'(1);   // Free running
			if (wr_pair) begin
				entries[slot1] <= release_of(last_evt);
				entries[slot2] <= new_evt;
				wr_ptr         <= slot2;
			end else if (wr_single) begin
				entries[slot1] <= new_evt;
				wr_ptr         <= slot1;
			end
			if (&pace_cnt && rd_ptr != wr_ptr)
				rd_ptr <= rd_ptr + ONE;
		end
	end

	// ====================
	// Checks
	// ====================

	logic [PTR_W:0] fill_after;   // Unread entries once this write lands

	assign fill_after = {1'b0, wr_ptr - rd_ptr} + (wr_pair ? 2 : 1);

	// Writer must never reach the entry the reader is still showing
	a_no_overrun: assert property (
		@(posedge CLK12) disable iff (RESET)
		(wr_pair || wr_single) |-> (fill_after < QUEUE_DEPTH)
	);

endmodule

// ==== keyboard/kbd_scan_translate.sv ====
/* PS/2 to ABC80 character translator
   Maps scan code plus Shift, Ctrl and Caps-Lock to a character and key-down flag */
`timescale 1ns/1ps

module kbd_scan_translate import abc80_kbd_pkg::*; (
	input  logic       CLK12,
	input  logic       RESET,
	input  logic       key_strobe,
	input  logic       key_pressed,
	input  logic       key_extended,
	input  logic [7:0] key_code,
	input  logic       shift,
	input  logic       ctrl,
	input  logic       upcase,
	output logic       key_down,
	output key_char_t  key_char
);

	scan_code_t scan;
	key_char_t  case_bit;
	key_char_t  next_char;
	logic       hit;

	assign scan = {key_extended, key_code};

	// Lower case when Shift and Caps-Lock agree
	assign case_bit = {1'b0, shift == upcase, 5'd0};

	// ====================
	// Mapping table
	// ====================

	always_comb begin
		hit       = 1'b1;
		next_char = '0;
		casez ({ctrl, shift, scan})
			{2'b0?, 9'h01C}: next_char = 7'h41 | case_bit;   // A
			{2'b0?, 9'h032}: next_char = 7'h42 | case_bit;   // B
			{2'b0?, 9'h021}: next_char = 7'h43 | case_bit;   // C
			{2'b0?, 9'h023}: next_char = 7'h44 | case_bit;   // D
			{2'b0?, 9'h024}: next_char = 7'h45 | case_bit;   // E
			{2'b0?, 9'h02B}: next_char = 7'h46 | case_bit;   // F
			{2'b0?, 9'h034}: next_char = 7'h47 | case_bit;   // G
			{2'b0?, 9'h033}: next_char = 7'h48 | case_bit;   // H
			{2'b0?, 9'h043}: next_char = 7'h49 | case_bit;   // I
			{2'b0?, 9'h03B}: next_char = 7'h4A | case_bit;   // J
			{2'b0?, 9'h042}: next_char = 7'h4B | case_bit;   // K
			{2'b0?, 9'h04B}: next_char = 7'h4C | case_bit;   // L
			{2'b0?, 9'h03A}: next_char = 7'h4D | case_bit;   // M
			{2'b0?, 9'h031}: next_char = 7'h4E | case_bit;   // N
			{2'b0?, 9'h044}: next_char = 7'h4F | case_bit;   // O
			{2'b0?, 9'h04D}: next_char = 7'h50 | case_bit;   // P
			{2'b0?, 9'h015}: next_char = 7'h51 | case_bit;   // Q
			{2'b0?, 9'h02D}: next_char = 7'h52 | case_bit;   // R
			{2'b0?, 9'h01B}: next_char = 7'h53 | case_bit;   // S
			{2'b0?, 9'h02C}: next_char = 7'h54 | case_bit;   // T
			{2'b0?, 9'h03C}: next_char = 7'h55 | case_bit;   // U
			{2'b0?, 9'h02A}: next_char = 7'h56 | case_bit;   // V
			{2'b0?, 9'h01D}: next_char = 7'h57 | case_bit;   // W
			{2'b0?, 9'h022}: next_char = 7'h58 | case_bit;   // X
			{2'b0?, 9'h035}: next_char = 7'h59 | case_bit;   // Y
			{2'b0?, 9'h01A}: next_char = 7'h5A | case_bit;   // Z

			// Swedish keys follow the letter rule
			{2'b0?, 9'h055}: next_char = 7'h40 | case_bit;
			{2'b0?, 9'h054}: next_char = 7'h5D | case_bit;
			{2'b0?, 9'h05B}: next_char = 7'h5E | case_bit;
			{2'b0?, 9'h04C}: next_char = 7'h5C | case_bit;
			{2'b0?, 9'h052}: next_char = 7'h5B | case_bit;

			{2'b00, 9'h016}: next_char = 7'h31;   // 1
			{2'b00, 9'h01E}: next_char = 7'h32;
			{2'b00, 9'h026}: next_char = 7'h33;
			{2'b00, 9'h025}: next_char = 7'h34;
			{2'b00, 9'h02E}: next_char = 7'h35;
			{2'b00, 9'h036}: next_char = 7'h36;
			{2'b00, 9'h03D}: next_char = 7'h37;
			{2'b00, 9'h03E}: next_char = 7'h38;
			{2'b00, 9'h046}: next_char = 7'h39;
			{2'b00, 9'h045}: next_char = 7'h30;   // 0

			{2'b00, 9'h069}: next_char = 7'h31;   // Keypad 1
			{2'b00, 9'h072}: next_char = 7'h32;
			{2'b00, 9'h07A}: next_char = 7'h33;
			{2'b00, 9'h06B}: next_char = 7'h34;
			{2'b00, 9'h073}: next_char = 7'h35;
			{2'b00, 9'h074}: next_char = 7'h36;
			{2'b00, 9'h06C}: next_char = 7'h37;
			{2'b00, 9'h075}: next_char = 7'h38;
			{2'b00, 9'h07D}: next_char = 7'h39;
			{2'b00, 9'h070}: next_char = 7'h30;   // Keypad 0

			{2'b01, 9'h016}: next_char = 7'h21;   // !
			{2'b01, 9'h01E}: next_char = 7'h22;
			{2'b01, 9'h026}: next_char = 7'h23;
			{2'b01, 9'h025}: next_char = 7'h24;
			{2'b01, 9'h02E}: next_char = 7'h25;
			{2'b01, 9'h036}: next_char = 7'h26;
			{2'b01, 9'h03D}: next_char = 7'h2F;   // Swedish layout puts / on 7
			{2'b01, 9'h03E}: next_char = 7'h28;
			{2'b01, 9'h046}: next_char = 7'h29;
			{2'b01, 9'h045}: next_char = 7'h3D;   // =

			{2'b00, 9'h?5A}: next_char = KC_CR;      // Enter, main or keypad
			{2'b00, 9'h029}: next_char = KC_SPACE;
			{2'b00, 9'h16B}: next_char = KC_BS;      // Cursor left
			{2'b00, 9'h066}: next_char = KC_BS;
			{2'b00, 9'h174}: next_char = KC_HT;      // Cursor right
			{2'b10, 9'h021}: next_char = KC_ETX;
			{2'b10, 9'h022}: next_char = KC_CAN;

			{2'b00, 9'h041}: next_char = 7'h2C;   // ,
			{2'b00, 9'h049}: next_char = 7'h2E;   // .
			{2'b00, 9'h04A}: next_char = 7'h2D;   // -
			{2'b00, 9'h04E}: next_char = 7'h2B;   // +
			{2'b00, 9'h05D}: next_char = 7'h27;
			{2'b00, 9'h00E}: next_char = 7'h3C;   // <

			{2'b01, 9'h041}: next_char = 7'h3B;   // ;
			{2'b01, 9'h049}: next_char = 7'h3A;   // :
			{2'b01, 9'h04A}: next_char = 7'h5F;   // _
			{2'b01, 9'h04E}: next_char = 7'h3F;   // ?
			{2'b01, 9'h05D}: next_char = 7'h2A;   // *
			{2'b01, 9'h00E}: next_char = 7'h3E;   // >
			{2'b1?, 9'h00E}: next_char = KC_DEL;

			default:         hit = 1'b0;          // Modifiers and unknown keys
		endcase
	end

	// ====================
	// Output register
	// ====================

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			key_down <= 1'b0;
			key_char <= '0;
		end else if (key_strobe && hit) begin
			key_down <= key_pressed;
			key_char <= next_char;
		end
	end

	// Last key only moves on a key event or on reset
	a_key_after_strobe: assert property (
		@(posedge CLK12) disable iff (RESET)
		!$stable({key_down, key_char}) |-> ($past(key_strobe) || $past(RESET))
	);

endmodule

// ==== keyboard/kbd_modifiers.sv ====
/* Keyboard modifier register
   Follows Shift and Ctrl from PS/2 events, Caps-Lock presses toggle upcase */
`timescale 1ns/1ps

module kbd_modifiers import abc80_kbd_pkg::*; (
	input  logic       CLK12,
	input  logic       RESET,
	input  logic       key_strobe,
	input  logic       key_pressed,
	input  logic       key_extended,
	input  logic [7:0] key_code,
	output logic       shift,
	output logic       ctrl,
	output logic       upcase
);

	scan_code_t scan;
	logic       is_shift;
	logic       is_ctrl;
	logic       is_caps;

	assign scan     = {key_extended, key_code};
	assign is_shift = (scan == SC_LSHIFT) || (scan == SC_RSHIFT);
	assign is_ctrl  = (key_code == SC_CTRL[7:0]);   // Right Ctrl carries E0
	assign is_caps  = (scan == SC_CAPS);

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			shift  <= 1'b0;
			ctrl   <= 1'b0;
			upcase <= 1'b0;
		end else if (key_strobe) begin
			if (is_shift)
				shift <= key_pressed;
			if (is_ctrl)
				ctrl <= key_pressed;
			if (is_caps && key_pressed)
				upcase <= ~upcase;   // Break leaves it alone
		end
	end

	// ====================
	// Checks
	// ====================

	// The indicator only moves on a key event or on reset
	a_upcase_after_strobe: assert property (
		@(posedge CLK12) disable iff (RESET)
		!$stable(upcase) |-> ($past(key_strobe) || $past(RESET))
	);

endmodule

// ==== common/abc80_kbd_pkg.sv ====
/* ABC80 keyboard front end shared definitions
   Scan code and character types, modifier scan codes and control characters */
package abc80_kbd_pkg;

	// ====================
	// Types
	// ====================

	// Extended flag above the 8-bit PS/2 code
	typedef logic [8:0] scan_code_t;

	// ABC80 character code
	typedef logic [6:0] key_char_t;

	// One queue entry as read by the port-A reader
	typedef struct packed {
		logic      down;   // Key-down flag
		key_char_t chr;    // Character code
	} key_byte_t;

	// ====================
	// Modifier scan codes
	// ====================

	localparam scan_code_t SC_LSHIFT = 9'h012;
	localparam scan_code_t SC_RSHIFT = 9'h059;
	localparam scan_code_t SC_CTRL   = 9'h014;   // Left or right, E0 flag ignored
	localparam scan_code_t SC_CAPS   = 9'h058;

	// ====================
	// Control characters
	// ====================

	localparam key_char_t KC_ETX   = 7'h03;   // Ctrl+C break
	localparam key_char_t KC_BS    = 7'h08;   // Backspace and cursor left
	localparam key_char_t KC_HT    = 7'h09;   // Cursor right
	localparam key_char_t KC_CR    = 7'h0D;
	localparam key_char_t KC_CAN   = 7'h18;   // Ctrl+X
	localparam key_char_t KC_SPACE = 7'h20;
	localparam key_char_t KC_DEL   = 7'h7F;

	// Release byte for a stored press, same character with the flag cleared
	function automatic key_byte_t release_of(key_byte_t k);
		key_byte_t r;
		r      = k;
		r.down = 1'b0;
		return r;
	endfunction

endpackage
